// ==== arb_defines.svh ====
`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

// ------------------------------
// Transport path sizing
// ------------------------------

// Number of requesters, must be 2 or more
`define ARB_NUM_SRC 4

// Payload width of one requester word
`define ARB_DATA_W 16

// Source index width, follows from the requester count
`define ARB_SRC_W $clog2(`ARB_NUM_SRC)

// Buffer entries between producer and consumer, 2 or more
`define ARB_FIFO_DEPTH 4

// Width of each per-source accepted-item counter, wraps on overflow
`define ARB_CNT_W 16

`endif

// ==== arb_pkg.sv ====
`default_nettype none

`include "arb_defines.svh"

package arb_pkg;

  // ------------------------------
  // Shared vector types
  // ------------------------------

  // One requester payload word
  typedef logic [`ARB_DATA_W-1:0] payload_t;

  // Index of the requester that produced a word
  typedef logic [`ARB_SRC_W-1:0] src_t;

  // One per-source accepted-item count
  typedef logic [`ARB_CNT_W-1:0] cnt_t;

endpackage : arb_pkg

`default_nettype wire

// ==== arb_rr.sv ====
`timescale 1ns/1ps
`default_nettype none

module arb_rr #(
  parameter int num_src = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               enable,
  input  logic [num_src-1:0] request,
  output logic [num_src-1:0] grant
);

  // ------------------------------
  // Priority state
  // ------------------------------

  // One-hot pointer to the requester with top priority
  logic [num_src-1:0] prio_q;

  // Requests at or above the priority position
  logic [num_src-1:0] req_upper;

  // Lowest set bit of the upper and of the full request vector
  logic [num_src-1:0] first_upper;
  logic [num_src-1:0] first_any;

  // Priority after the current winner, rotated by one with wrap
  logic [num_src-1:0] prio_next;

  // ------------------------------
  // Grant search
  // ------------------------------

  // Subtracting one from a one-hot word sets every bit below it
  assign req_upper = request & ~(prio_q - {{(num_src-1){1'b0}}, 1'b1});

  // Two's complement trick isolates the lowest set bit
  assign first_upper = req_upper & (~req_upper + {{(num_src-1){1'b0}}, 1'b1});
  assign first_any   = request & (~request + {{(num_src-1){1'b0}}, 1'b1});

  // Wrap to the bottom only when nothing waits at or above priority
  always_comb begin
    if (|req_upper) begin
      grant = first_upper;
    end else begin
      grant = first_any;
    end
  end

  // Winner moves to the back of the queue
  assign prio_next = {grant[num_src-2:0], grant[num_src-1]};

  // ------------------------------
  // Priority update
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Index 0 starts out on top
      prio_q <= {{(num_src-1){1'b0}}, 1'b1};
    end else if (enable && |grant) begin
      // Only a taken grant moves priority
      prio_q <= prio_next;
    end
  end

endmodule : arb_rr

`default_nettype wire

// ==== flow_arb_rr.sv ====
`timescale 1ns/1ps
`default_nettype none

module flow_arb_rr #(
  parameter int num_src = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [num_src-1:0] push_valid,
  output logic [num_src-1:0] push_ready,
  input  logic               pop_ready,
  output logic               pop_valid,
  output logic [num_src-1:0] grant
);

  // Core arbiter whose priority moves only when the pop side takes the word
  arb_rr #(
    .num_src(num_src)
  ) u_arb_rr (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (pop_ready),
    .request(push_valid),
    .grant  (grant)
  );

  // ------------------------------
  // Push-ready per requester
  // ------------------------------

  // Ready is blocked by any grant held by another requester
  // Own valid never enters so ready has no loop through valid
  for (genvar i = 0; i < num_src; i++) begin : gen_push_ready
    localparam logic [num_src-1:0] own_bit = num_src'(1) << i;

    assign push_ready[i] = pop_ready && !(|(grant & ~own_bit));
  end

  // Any valid requester means a word is on offer downstream
  assign pop_valid = |push_valid;

endmodule : flow_arb_rr

`default_nettype wire

// ==== flow_mux_rr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module flow_mux_rr import arb_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`ARB_NUM_SRC-1:0]      push_valid,
  output logic [`ARB_NUM_SRC-1:0]      push_ready,
  input  payload_t [`ARB_NUM_SRC-1:0]  push_data,
  output logic                         mux_valid,
  input  logic                         mux_ready,
  output payload_t                     mux_data,
  output src_t                         mux_src
);

  // ------------------------------
  // Arbitration
  // ------------------------------

  // One-hot winner of the current cycle
  logic [`ARB_NUM_SRC-1:0] grant;

  flow_arb_rr #(
    .num_src(`ARB_NUM_SRC)
  ) u_flow_arb_rr (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .pop_ready (mux_ready),
    .pop_valid (mux_valid),
    .grant     (grant)
  );

  // ------------------------------
  // Source tag and data select
  // ------------------------------

  // One-hot to binary, grant has at most one bit set
  always_comb begin
    mux_src = '0;
    for (int i = 0; i < `ARB_NUM_SRC; i++) begin
      if (grant[i]) begin
        mux_src = src_t'(i);
      end
    end
  end

  // Winner's payload passes straight through, no register on the path
  // With no grant this shows source 0, but mux_valid is low then
  assign mux_data = push_data[mux_src];

endmodule : flow_mux_rr

`default_nettype wire

// ==== fifo_flops.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_flops import arb_pkg::*; #(
  parameter int depth = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_valid,
  output logic     push_ready,
  input  payload_t push_data,
  input  src_t     push_src,
  output logic     pop_valid,
  input  logic     pop_ready,
  output payload_t pop_data,
  output src_t     pop_src
);

  // ------------------------------
  // Sizing
  // ------------------------------

  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);

  // Pointers wrap after the last storage index
  localparam logic [ptr_w-1:0] last_idx = ptr_w'(depth - 1);

  // ------------------------------
  // State
  // ------------------------------

  // Storage flops hold payload and source tag side by side
  payload_t mem_data [depth];
  src_t     mem_src  [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;

  // Number of words held
  logic [cnt_w-1:0] count;

  logic full;
  logic empty;
  logic push_fire;
  logic pop_fire;

  assign full  = (count == cnt_w'(depth));
  assign empty = (count == '0);

  // A full buffer still takes a word when one leaves the same cycle
  assign push_ready = !full || pop_ready;
  assign pop_valid  = !empty;

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave the count unchanged
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage write at the write pointer
  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem_data[wr_ptr] <= push_data;
      mem_src[wr_ptr]  <= push_src;
    end
  end

  // Head of the queue
  assign pop_data = mem_data[rd_ptr];
  assign pop_src  = mem_src[rd_ptr];

endmodule : fifo_flops

`default_nettype wire

// ==== flow_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module flow_drain import arb_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     buf_valid,
  output logic                     buf_ready,
  input  payload_t                 buf_data,
  input  src_t                     buf_src,
  output logic                     out_valid,
  input  logic                     out_ready,
  output payload_t                 out_data,
  output src_t                     out_src,
  output cnt_t [`ARB_NUM_SRC-1:0]  src_count
);

  // Word moves from the buffer into the output register
  logic buf_fire;

  // ------------------------------
  // Output register
  // ------------------------------

  // Take a new word when the register is empty or being emptied now
  assign buf_ready = !out_valid || out_ready;
  assign buf_fire  = buf_valid && buf_ready;

  // Valid flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (buf_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      // Word left and nothing replaced it
      out_valid <= 1'b0;
    end
  end

  // Payload and tag, held while out_ready is low
  always_ff @(posedge clk) begin
    if (buf_fire) begin
      out_data <= buf_data;
      out_src  <= buf_src;
    end
  end

  // ------------------------------
  // Per-source counters
  // ------------------------------

  // One count per accepted word of each source, wraps at full scale
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      src_count <= '0;
    end else if (buf_fire) begin
      src_count[buf_src] <= src_count[buf_src] + cnt_t'(1);
    end
  end

endmodule : flow_drain

`default_nettype wire

// ==== arb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module arb_top import arb_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`ARB_NUM_SRC-1:0]      push_valid,
  output logic [`ARB_NUM_SRC-1:0]      push_ready,
  input  payload_t [`ARB_NUM_SRC-1:0]  push_data,
  output logic                         out_valid,
  input  logic                         out_ready,
  output payload_t                     out_data,
  output src_t                         out_src,
  output cnt_t [`ARB_NUM_SRC-1:0]      src_count
);

  // ------------------------------
  // Internal links
  // ------------------------------

  // Arbiter to buffer
  logic     mux_valid;
  logic     mux_ready;
  payload_t mux_data;
  src_t     mux_src;

  // Buffer to drain
  logic     buf_valid;
  logic     buf_ready;
  payload_t buf_data;
  src_t     buf_src;

  // Producer, zero-cycle arbitration and source tag
  flow_mux_rr u_flow_mux_rr (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_data (push_data),
    .mux_valid (mux_valid),
    .mux_ready (mux_ready),
    .mux_data  (mux_data),
    .mux_src   (mux_src)
  );

  // Buffer, one cycle minimum latency
  fifo_flops #(
    .depth(`ARB_FIFO_DEPTH)
  ) u_fifo_flops (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_valid(mux_valid),
    .push_ready(mux_ready),
    .push_data (mux_data),
    .push_src  (mux_src),
    .pop_valid (buf_valid),
    .pop_ready (buf_ready),
    .pop_data  (buf_data),
    .pop_src   (buf_src)
  );

  // Consumer, registered output and counters
  flow_drain u_flow_drain (
    .clk      (clk),
    .rst_n    (rst_n),
    .buf_valid(buf_valid),
    .buf_ready(buf_ready),
    .buf_data (buf_data),
    .buf_src  (buf_src),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .out_src  (out_src),
    .src_count(src_count)
  );

endmodule : arb_top

`default_nettype wire

// ==== tb_arb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module tb_arb_top import arb_pkg::*; ();

  // ------------------------------
  // Run sizing
  // ------------------------------

  localparam int num_src      = `ARB_NUM_SRC;
  localparam int fifo_depth   = `ARB_FIFO_DEPTH;
  localparam int clk_period   = 8;
  localparam int num_phases   = 4;
  localparam int phase_budget = 2000;
  localparam int watchdog_ns  = num_phases * phase_budget * clk_period;

  // Payload carries the source in the top nibble and a sequence number below
  localparam int seq_w = `ARB_DATA_W - 4;

  // ------------------------------
  // DUT signals
  // ------------------------------

  logic                      clk        = 1'b0;
  logic                      rst_n      = 1'b0;
  logic [num_src-1:0]        push_valid = '0;
  logic [num_src-1:0]        push_ready;
  payload_t [num_src-1:0]    push_data  = '0;
  logic                      out_valid;
  logic                      out_ready  = 1'b1;
  payload_t                  out_data;
  src_t                      out_src;
  cnt_t [num_src-1:0]        src_count;

  // Traffic knobs in percent chance per cycle
  int   valid_pct = 100;
  int   out_pct   = 100;
  logic rr_mode   = 1'b1;

  // Scoreboard state
  payload_t exp_q [num_src][$];
  int       push_count [num_src];
  int       drv_seq [num_src];
  int       in_flight = 0;
  int       out_total = 0;
  src_t     rr_expect = '0;
  logic     push_fire;
  logic     out_fire;
  logic     fifo_full;

  // Output word seen on the previous edge
  logic     held_valid;
  payload_t held_data;
  src_t     held_src;

  arb_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_data (push_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_src   (out_src),
    .src_count (src_count)
  );

  always #(clk_period / 2) clk = ~clk;

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic payload_t make_payload(input int src, input int seq);
    return payload_t'((src << seq_w) | (seq % (1 << seq_w)));
  endfunction

  task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    stop_run();
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    stop_run();
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_outs(input int n);
    int target;
    target = out_total + n;
    while (out_total < target) @(posedge clk);
  endtask

  // Nothing offered and nothing left inside the path
  task automatic wait_drained();
    @(posedge clk);
    while (push_valid != '0 || in_flight != 0) @(posedge clk);
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------

  // Valid and data hold until taken and then move to the next word of that source
  always @(posedge clk) begin
    out_ready <= ($urandom_range(99) < out_pct);
    for (int s = 0; s < num_src; s++) begin
      if (!rst_n) begin
        push_valid[s] <= 1'b0;
      end else if (push_valid[s] && push_ready[s]) begin
        drv_seq[s] = drv_seq[s] + 1;
        push_valid[s] <= ($urandom_range(99) < valid_pct);
        push_data[s]  <= make_payload(s, drv_seq[s]);
      end else if (!push_valid[s] && ($urandom_range(99) < valid_pct)) begin
        push_valid[s] <= 1'b1;
        push_data[s]  <= make_payload(s, drv_seq[s]);
      end
    end
  end

  // ------------------------------
  // Scoreboard
  // ------------------------------

  assign push_fire = |(push_valid & push_ready);
  assign out_fire  = out_valid && out_ready;

  // FIFO holds whatever is in flight minus the word in the output register
  assign fifo_full = (in_flight - int'(out_valid)) == fifo_depth;

  always @(posedge clk) begin
    held_valid <= out_valid;
    held_data  <= out_data;
    held_src   <= out_src;
    if (!rst_n) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(push_fire) - int'(out_fire);
      out_total <= out_total + int'(out_fire);
    end
  end

  always @(posedge clk) begin
    payload_t exp_word;
    if (rst_n) begin
      if (out_fire) begin
        assert (exp_q[out_src].size() != 0)
          else report_failure($sformatf("word from source %0d with none outstanding", out_src));
        exp_word = exp_q[out_src].pop_front();
        assert (out_data == exp_word) else report_mismatch("out_data", exp_word, out_data);
        if (rr_mode) begin
          assert (out_src == rr_expect) else report_mismatch("out_src", rr_expect, out_src);
          rr_expect = (rr_expect == src_t'(num_src - 1)) ? '0 : rr_expect + 1'b1;
        end
      end
      // Each accepted push queues the next word in its source's sequence
      for (int s = 0; s < num_src; s++) begin
        if (push_valid[s] && push_ready[s]) begin
          exp_q[s].push_back(make_payload(s, push_count[s]));
          push_count[s] = push_count[s] + 1;
        end
      end
    end
  end

  // ------------------------------
  // Protocol checks
  // ------------------------------

  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(push_valid & push_ready))
    else report_failure("more than one push handshake in a cycle");

  for (genvar i = 0; i < num_src; i++) begin : gen_ready_rule
    localparam logic [num_src-1:0] own_bit = num_src'(1) << i;
    assert property (@(posedge clk) disable iff (!rst_n)
      push_valid[i] && !push_ready[i] |-> (|(push_valid & push_ready & ~own_bit)) || fifo_full)
      else report_failure($sformatf("source %0d stalled with no other handshake", i));
  end

  // Stalled output must not move
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid == held_valid)
    else report_mismatch("out_valid", $sampled(held_valid), $sampled(out_valid));
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_data == held_data)
    else report_mismatch("out_data", $sampled(held_data), $sampled(out_data));
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_src == held_src)
    else report_mismatch("out_src", $sampled(held_src), $sampled(out_src));

  // FIFO plus output register full and stalled
  assert property (@(posedge clk) disable iff (!rst_n)
    in_flight >= fifo_depth + 1 && !out_ready |-> push_ready == '0)
    else report_mismatch("push_ready", 0, $sampled(push_ready));
  assert property (@(posedge clk) disable iff (!rst_n) in_flight <= fifo_depth + 1)
    else report_failure("more words accepted than the path can hold");

  // ------------------------------
  // Watchdog
  // ------------------------------

  initial begin
    #(watchdog_ns);
    report_failure("timeout, test phases did not finish in time");
  end

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    void'($urandom(32'h1656_0397));
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // State straight out of reset
    assert (out_valid == 1'b0) else report_mismatch("out_valid", 0, out_valid);
    for (int s = 0; s < num_src; s++) begin
      assert (src_count[s] == '0)
        else report_mismatch($sformatf("src_count[%0d]", s), 0, src_count[s]);
    end

    // Phase 1 keeps all sources busy in round-robin order
    wait_outs(40);
    valid_pct <= 0;
    wait_drained();
    rr_mode <= 1'b0;

    // Phase 2 mixes random offers with a random consumer
    valid_pct <= 50;
    out_pct   <= 70;
    run_cycles(400);
    valid_pct <= 0;
    out_pct   <= 100;
    wait_drained();

    // Phase 3 stops the consumer until the path is full
    out_pct   <= 0;
    valid_pct <= 100;
    while (in_flight < fifo_depth + 1) @(posedge clk);
    run_cycles(24);
    valid_pct <= 0;
    out_pct   <= 100;
    wait_drained();

    // Phase 4 puts heavy load on a slow consumer
    valid_pct <= 85;
    out_pct   <= 30;
    run_cycles(500);
    valid_pct <= 0;
    out_pct   <= 100;
    wait_drained();

    // Settled values are read away from the clock edge
    run_cycles(4);
    @(negedge clk);
    for (int s = 0; s < num_src; s++) begin
      assert (exp_q[s].size() == 0)
        else report_failure($sformatf("source %0d has words that never came out", s));
      assert (src_count[s] == cnt_t'(push_count[s]))
        else report_mismatch($sformatf("src_count[%0d]", s), cnt_t'(push_count[s]),
                             src_count[s]);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : tb_arb_top

`default_nettype wire

// ==== filelist.f ====
+incdir+.
arb_pkg.sv
arb_rr.sv
flow_arb_rr.sv
flow_mux_rr.sv
fifo_flops.sv
flow_drain.sv
arb_top.sv
tb_arb_top.sv

// ==== Bender.yml ====
package:
  name: arb_rr_path

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - arb_pkg.sv
      - arb_rr.sv
      - flow_arb_rr.sv
      - flow_mux_rr.sv
      - fifo_flops.sv
      - flow_drain.sv
      - arb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_arb_top.sv
